// ==== pipeCpu.f ====
+incdir+src
src/isaPkg.sv
src/pipePkg.sv
src/regFile.sv
src/alu.sv
src/controller.sv
src/hazardUnit.sv
src/datapath.sv
src/pipeCpu.sv
tests/pipeCpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM=pipeCpuSim

verilator --binary --timing --top-module pipeCpuTb --Mdir "$BUILD_DIR" -o "$SIM" -f pipeCpu.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

# The log decides the verdict
if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0

// ==== tests/pipeCpuTb.sv ====
`include "cpuDefs_defs.svh"

module pipeCpuTb;

  localparam int ClkPeriod    = 40;
  localparam int ResetCycles  = 4;
  localparam int MaxWait      = 60;
  localparam int DrainCycles  = 6;
  localparam int NumTests     = 5;
  localparam int MaxInstr     = 16;
  localparam int MaxStores    = 8;
  localparam int ImemAddrBits = $clog2(`IMEM_WORDS);
  localparam int DmemAddrBits = $clog2(`DMEM_WORDS);
  // Longest possible run plus some margin
  localparam int WatchdogCycles = NumTests * (ResetCycles + 1 + MaxWait + DrainCycles) + 16;
  localparam logic [31:0] LfsrSeed = 32'h8e9c;

  // ARM data-processing cmd field
  localparam logic [3:0] CmdAnd = 4'b0000;
  localparam logic [3:0] CmdEor = 4'b0001;
  localparam logic [3:0] CmdSub = 4'b0010;
  localparam logic [3:0] CmdAdd = 4'b0100;
  localparam logic [3:0] CmdOrr = 4'b1100;
  localparam logic [3:0] CmdMov = 4'b1101;

  logic                   clk;
  logic                   arstN;
  logic [`DATA_WIDTH-1:0] pc;
  logic [`DATA_WIDTH-1:0] instr;
  logic                   memWrite;
  logic [`DATA_WIDTH-1:0] dataAddr;
  logic [`DATA_WIDTH-1:0] writeData;
  logic [`DATA_WIDTH-1:0] readData;

  logic [`DATA_WIDTH-1:0] imem [`IMEM_WORDS];
  logic [`DATA_WIDTH-1:0] dmem [`DMEM_WORDS];
  logic [`DATA_WIDTH-1:0] storeAddrQ [$];
  logic [`DATA_WIDTH-1:0] storeDataQ [$];

  // Stimulus table
  string       testName   [NumTests];
  logic [31:0] progWords  [NumTests][MaxInstr];
  int          storeCount [NumTests];
  logic [31:0] expAddr    [NumTests][MaxStores];
  logic [31:0] expData    [NumTests][MaxStores];

  logic [31:0] lfsrState = LfsrSeed;
  logic        testOk;
  int          passCount;
  int          failCount;

  pipeCpu uut (
    .clk       (clk),
    .arstN     (arstN),
    .pc        (pc),
    .instr     (instr),
    .memWrite  (memWrite),
    .dataAddr  (dataAddr),
    .writeData (writeData),
    .readData  (readData)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Words past the program read as never-executed NOPs
  assign instr    = (pc < 4 * `IMEM_WORDS) ? imem[pc[ImemAddrBits+1:2]] : '0;
  assign readData = dmem[dataAddr[DmemAddrBits+1:2]];

  always @(posedge clk) begin
    if (memWrite) begin
      dmem[dataAddr[DmemAddrBits+1:2]] <= writeData;
      storeAddrQ.push_back(dataAddr);
      storeDataQ.push_back(writeData);
    end
  end

  function automatic logic [31:0] dpImm(input logic [3:0] cmd, input logic [3:0] rd,
                                        input logic [3:0] rn, input logic [7:0] imm);
    return {4'hE, 2'b00, 1'b1, cmd, 1'b0, rn, rd, 4'h0, imm};
  endfunction

  function automatic logic [31:0] dpReg(input logic [3:0] cmd, input logic [3:0] rd,
                                        input logic [3:0] rn, input logic [3:0] rm);
    return {4'hE, 2'b00, 1'b0, cmd, 1'b0, rn, rd, 8'h00, rm};
  endfunction

  // Pre-indexed word access with added offset and no writeback
  function automatic logic [31:0] storeOp(input logic [3:0] rd, input logic [3:0] rn,
                                          input logic [11:0] offset);
    return {4'hE, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, rn, rd, offset};
  endfunction

  function automatic logic [31:0] loadOp(input logic [3:0] rd, input logic [3:0] rn,
                                         input logic [11:0] offset);
    return {4'hE, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, rn, rd, offset};
  endfunction

  function automatic logic [31:0] branchOp(input logic [23:0] offset);
    return {4'hE, 3'b101, 1'b0, offset};
  endfunction

  // Fibonacci LFSR step with taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // One LFSR step per bit drawn
  task automatic drawBits(input int width, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < width; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value     = {value[30:0], lfsrState[0]};
    end
  endtask

  task automatic checkValue(input string sigName, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, sigName, got, expected);
      testOk = 1'b0;
    end
  endtask

  task automatic addStore(input int t, input logic [31:0] addr, input logic [31:0] value);
    expAddr[t][storeCount[t]] = addr;
    expData[t][storeCount[t]] = value;
    storeCount[t]++;
  endtask

  task automatic buildTable();
    logic [31:0] a, b, c, d, x2, x3, x4, x5, x6;
    int t;
    int i;
    for (t = 0; t < NumTests; t++) begin
      storeCount[t] = 0;
      for (i = 0; i < MaxInstr; i++) begin
        progWords[t][i] = '0;
      end
    end

    testName[0] = "reset";
    drawBits(8, a);
    progWords[0][0] = dpImm(CmdMov, 4'd0, 4'd0, 8'd0);
    progWords[0][1] = dpImm(CmdMov, 4'd1, 4'd0, a[7:0]);
    progWords[0][2] = storeOp(4'd1, 4'd0, 12'h030);
    addStore(0, 32'h30, a);

    // Each result stored right after it is made
    testName[1] = "alu";
    drawBits(8, a);
    drawBits(8, b);
    progWords[1][0]  = dpImm(CmdMov, 4'd0, 4'd0, 8'd0);
    progWords[1][1]  = dpImm(CmdMov, 4'd1, 4'd0, a[7:0]);
    progWords[1][2]  = dpImm(CmdMov, 4'd2, 4'd0, b[7:0]);
    progWords[1][3]  = dpReg(CmdAnd, 4'd3, 4'd1, 4'd2);
    progWords[1][4]  = storeOp(4'd3, 4'd0, 12'h000);
    progWords[1][5]  = dpReg(CmdEor, 4'd4, 4'd1, 4'd2);
    progWords[1][6]  = storeOp(4'd4, 4'd0, 12'h004);
    progWords[1][7]  = dpReg(CmdSub, 4'd5, 4'd1, 4'd2);
    progWords[1][8]  = storeOp(4'd5, 4'd0, 12'h008);
    progWords[1][9]  = dpReg(CmdAdd, 4'd6, 4'd1, 4'd2);
    progWords[1][10] = storeOp(4'd6, 4'd0, 12'h00C);
    progWords[1][11] = dpReg(CmdOrr, 4'd7, 4'd1, 4'd2);
    progWords[1][12] = storeOp(4'd7, 4'd0, 12'h010);
    addStore(1, 32'h00, a & b);
    addStore(1, 32'h04, a ^ b);
    addStore(1, 32'h08, a - b);
    addStore(1, 32'h0C, a + b);
    addStore(1, 32'h10, a | b);

    // Back-to-back dependent chain with the stores afterwards
    testName[2] = "forward";
    drawBits(8, a);
    drawBits(8, c);
    drawBits(8, d);
    x2 = a + c;
    x3 = x2 ^ a;
    x4 = x3 - x2;
    x5 = x4 | d;
    x6 = x5 & x3;
    progWords[2][0]  = dpImm(CmdMov, 4'd0, 4'd0, 8'd0);
    progWords[2][1]  = dpImm(CmdMov, 4'd1, 4'd0, a[7:0]);
    progWords[2][2]  = dpImm(CmdAdd, 4'd2, 4'd1, c[7:0]);
    progWords[2][3]  = dpReg(CmdEor, 4'd3, 4'd2, 4'd1);
    progWords[2][4]  = dpReg(CmdSub, 4'd4, 4'd3, 4'd2);
    progWords[2][5]  = dpImm(CmdOrr, 4'd5, 4'd4, d[7:0]);
    progWords[2][6]  = dpReg(CmdAnd, 4'd6, 4'd5, 4'd3);
    progWords[2][7]  = storeOp(4'd2, 4'd0, 12'h000);
    progWords[2][8]  = storeOp(4'd3, 4'd0, 12'h004);
    progWords[2][9]  = storeOp(4'd4, 4'd0, 12'h008);
    progWords[2][10] = storeOp(4'd5, 4'd0, 12'h00C);
    progWords[2][11] = storeOp(4'd6, 4'd0, 12'h010);
    addStore(2, 32'h00, x2);
    addStore(2, 32'h04, x3);
    addStore(2, 32'h08, x4);
    addStore(2, 32'h0C, x5);
    addStore(2, 32'h10, x6);

    testName[3] = "loaduse";
    drawBits(8, a);
    drawBits(8, c);
    progWords[3][0] = dpImm(CmdMov, 4'd0, 4'd0, 8'd0);
    progWords[3][1] = dpImm(CmdMov, 4'd1, 4'd0, a[7:0]);
    progWords[3][2] = storeOp(4'd1, 4'd0, 12'h020);
    progWords[3][3] = loadOp(4'd2, 4'd0, 12'h020);
    progWords[3][4] = dpImm(CmdAdd, 4'd3, 4'd2, c[7:0]);
    progWords[3][5] = storeOp(4'd3, 4'd0, 12'h024);
    addStore(3, 32'h20, a);
    addStore(3, 32'h24, a + c);

    // B at 0x08 lands on 0x1C and skips MOVs that would clobber r1
    testName[4] = "branch";
    drawBits(8, a);
    drawBits(8, b);
    drawBits(8, c);
    progWords[4][0] = dpImm(CmdMov, 4'd0, 4'd0, 8'd0);
    progWords[4][1] = dpImm(CmdMov, 4'd1, 4'd0, a[7:0]);
    progWords[4][2] = branchOp(24'd3);
    progWords[4][3] = dpImm(CmdMov, 4'd1, 4'd0, b[7:0]);
    progWords[4][4] = storeOp(4'd1, 4'd0, 12'h004);
    progWords[4][5] = dpImm(CmdMov, 4'd1, 4'd0, c[7:0]);
    progWords[4][6] = storeOp(4'd1, 4'd0, 12'h008);
    progWords[4][7] = storeOp(4'd1, 4'd0, 12'h00C);
    addStore(4, 32'h0C, a);
  endtask

  task automatic runTest(input int t);
    int cycles;
    int seen;
    int i;
    testOk = 1'b1;
    @(negedge clk);
    arstN = 1'b0;
    for (i = 0; i < `IMEM_WORDS; i++) begin
      if (i < MaxInstr) begin
        imem[i] = progWords[t][i];
      end else begin
        imem[i] = '0;
      end
    end
    storeAddrQ.delete();
    storeDataQ.delete();
    repeat (ResetCycles) begin
      @(negedge clk);
      checkValue("pc", pc, 32'd0);
      checkValue("memWrite", {31'b0, memWrite}, 32'd0);
    end
    arstN = 1'b1;

    cycles = 0;
    while (storeAddrQ.size() < storeCount[t] && cycles < MaxWait) begin
      @(negedge clk);
      cycles++;
    end
    // Let any stray stores drain out
    repeat (DrainCycles) @(negedge clk);

    seen = storeAddrQ.size();
    if (seen < storeCount[t]) begin
      $display("%s: only %0d of %0d stores reached memory within %0d cycles",
               testName[t], seen, storeCount[t], MaxWait);
      testOk = 1'b0;
    end
    if (seen > storeCount[t]) begin
      $display("%s: %0d stores were seen where %0d were expected",
               testName[t], seen, storeCount[t]);
      testOk = 1'b0;
    end
    for (i = 0; i < seen && i < storeCount[t]; i++) begin
      checkValue("dataAddr", storeAddrQ[i], expAddr[t][i]);
      checkValue("writeData", storeDataQ[i], expData[t][i]);
    end

    if (testOk) begin
      passCount++;
    end else begin
      failCount++;
    end
    $display("test %0d %s: %s", t, testName[t], testOk ? "passed" : "failed");
  endtask

  initial begin
    int t;
    int i;
    arstN     = 1'b0;
    passCount = 0;
    failCount = 0;
    for (i = 0; i < `IMEM_WORDS; i++) begin
      imem[i] = '0;
    end
    for (i = 0; i < `DMEM_WORDS; i++) begin
      dmem[i] = i * 32'h9E3779B1;
    end
    buildTable();
    for (t = 0; t < NumTests; t++) begin
      runTest(t);
    end
    $display("summary: %0d tests passed, %0d tests failed", passCount, failCount);
    if (failCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("watchdog: run did not finish within %0d cycles", WatchdogCycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== src/pipeCpu.sv ====
`include "cpuDefs_defs.svh"

module pipeCpu (
  input  logic                   clk,
  input  logic                   arstN,
  output logic [`DATA_WIDTH-1:0] pc,
  input  logic [`DATA_WIDTH-1:0] instr,
  output logic                   memWrite,
  output logic [`DATA_WIDTH-1:0] dataAddr,
  output logic [`DATA_WIDTH-1:0] writeData,
  input  logic [`DATA_WIDTH-1:0] readData
);

  logic [`DATA_WIDTH-1:0] instrD;
  logic [1:0]             regSrc;
  isaPkg::immSrcE         immSrc;
  logic                   aluSrcE;
  isaPkg::aluOpE          aluOpE;
  logic                   branchE;
  logic                   memToRegE;
  logic                   regWriteM;
  logic                   regWriteW;
  pipePkg::resultSrcE     resultSrcW;
  pipePkg::fwdSelE        fwdAE;
  pipePkg::fwdSelE        fwdBE;
  logic                   stallF;
  logic                   stallD;
  logic                   flushD;
  logic                   flushE;
  logic                   match1EM;
  logic                   match1EW;
  logic                   match2EM;
  logic                   match2EW;
  logic                   match12DE;

  controller ctrl (
    .clk        (clk),
    .arstN      (arstN),
    .instrD     (instrD),
    .flushE     (flushE),
    .regSrc     (regSrc),
    .immSrc     (immSrc),
    .aluSrcE    (aluSrcE),
    .aluOpE     (aluOpE),
    .branchE    (branchE),
    .memToRegE  (memToRegE),
    .memWriteM  (memWrite),
    .regWriteM  (regWriteM),
    .regWriteW  (regWriteW),
    .resultSrcW (resultSrcW)
  );

  hazardUnit hzd (
    .match1EM  (match1EM),
    .match1EW  (match1EW),
    .match2EM  (match2EM),
    .match2EW  (match2EW),
    .match12DE (match12DE),
    .regWriteM (regWriteM),
    .regWriteW (regWriteW),
    .memToRegE (memToRegE),
    .branchE   (branchE),
    .fwdAE     (fwdAE),
    .fwdBE     (fwdBE),
    .stallF    (stallF),
    .stallD    (stallD),
    .flushD    (flushD),
    .flushE    (flushE)
  );

  // Memory-stage ALU output doubles as the data address
  datapath dp (
    .clk        (clk),
    .arstN      (arstN),
    .regSrc     (regSrc),
    .immSrc     (immSrc),
    .aluSrcE    (aluSrcE),
    .aluOpE     (aluOpE),
    .branchE    (branchE),
    .resultSrcW (resultSrcW),
    .regWriteW  (regWriteW),
    .fwdAE      (fwdAE),
    .fwdBE      (fwdBE),
    .stallF     (stallF),
    .stallD     (stallD),
    .flushD     (flushD),
    .flushE     (flushE),
    .pc         (pc),
    .instr      (instr),
    .instrD     (instrD),
    .aluOutM    (dataAddr),
    .writeDataM (writeData),
    .readDataM  (readData),
    .match1EM   (match1EM),
    .match1EW   (match1EW),
    .match2EM   (match2EM),
    .match2EW   (match2EW),
    .match12DE  (match12DE)
  );

endmodule

// ==== src/datapath.sv ====
`include "cpuDefs_defs.svh"

module datapath (
  input  logic                       clk,
  input  logic                       arstN,
  input  logic [1:0]                 regSrc,
  input  isaPkg::immSrcE             immSrc,
  input  logic                       aluSrcE,
  input  isaPkg::aluOpE              aluOpE,
  input  logic                       branchE,
  input  pipePkg::resultSrcE         resultSrcW,
  input  logic                       regWriteW,
  input  pipePkg::fwdSelE            fwdAE,
  input  pipePkg::fwdSelE            fwdBE,
  input  logic                       stallF,
  input  logic                       stallD,
  input  logic                       flushD,
  input  logic                       flushE,
  output logic [`DATA_WIDTH-1:0]     pc,
  input  logic [`DATA_WIDTH-1:0]     instr,
  output logic [`DATA_WIDTH-1:0]     instrD,
  output logic [`DATA_WIDTH-1:0]     aluOutM,
  output logic [`DATA_WIDTH-1:0]     writeDataM,
  input  logic [`DATA_WIDTH-1:0]     readDataM,
  output logic                       match1EM,
  output logic                       match1EW,
  output logic                       match2EM,
  output logic                       match2EW,
  output logic                       match12DE
);

  logic [`DATA_WIDTH-1:0]     pcPlus4F;
  logic [`DATA_WIDTH-1:0]     pcNextF;
  logic [`DATA_WIDTH-1:0]     pcPlus8D;
  logic [`DATA_WIDTH-1:0]     rd1RawD;
  logic [`DATA_WIDTH-1:0]     rd1D;
  logic [`DATA_WIDTH-1:0]     rd2D;
  logic [`DATA_WIDTH-1:0]     extImmD;
  logic [`REG_ADDR_WIDTH-1:0] ra1D;
  logic [`REG_ADDR_WIDTH-1:0] ra2D;
  logic [`DATA_WIDTH-1:0]     rd1E;
  logic [`DATA_WIDTH-1:0]     rd2E;
  logic [`DATA_WIDTH-1:0]     extImmE;
  logic [`DATA_WIDTH-1:0]     srcAE;
  logic [`DATA_WIDTH-1:0]     srcBE;
  logic [`DATA_WIDTH-1:0]     writeDataE;
  logic [`DATA_WIDTH-1:0]     aluResultE;
  logic [`REG_ADDR_WIDTH-1:0] ra1E;
  logic [`REG_ADDR_WIDTH-1:0] ra2E;
  logic [`REG_ADDR_WIDTH-1:0] wa3E;
  logic [`REG_ADDR_WIDTH-1:0] wa3M;
  logic [`REG_ADDR_WIDTH-1:0] wa3W;
  logic [`DATA_WIDTH-1:0]     aluOutW;
  logic [`DATA_WIDTH-1:0]     readDataW;
  logic [`DATA_WIDTH-1:0]     resultW;

  function automatic logic [`DATA_WIDTH-1:0] fwdMux(
    input pipePkg::fwdSelE        sel,
    input logic [`DATA_WIDTH-1:0] regValue,
    input logic [`DATA_WIDTH-1:0] wbValue,
    input logic [`DATA_WIDTH-1:0] memValue
  );
    case (sel)
      pipePkg::FWD_WB:  return wbValue;
      pipePkg::FWD_MEM: return memValue;
      default:          return regValue;
    endcase
  endfunction

  // Fetch
  assign pcPlus4F = pc + 32'd4;
  assign pcNextF  = branchE ? aluResultE : pcPlus4F;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
    end else if (!stallF) begin
      pc <= pcNextF;
    end
  end

  // Decode
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instrD <= '0;
    end else if (flushD) begin
      instrD <= '0;
    end else if (!stallD) begin
      instrD <= instr;
    end
  end

  // Fetch is one word ahead, so its PC+4 is decode's PC+8
  assign pcPlus8D = pcPlus4F;

  assign ra1D = regSrc[0] ? 4'hF : instrD[19:16];
  assign ra2D = regSrc[1] ? instrD[15:12] : instrD[3:0];

  regFile rf (
    .clk        (clk),
    .writeEn    (regWriteW),
    .readAddr1  (ra1D),
    .readAddr2  (ra2D),
    .writeAddr  (wa3W),
    .writeValue (resultW),
    .readValue1 (rd1RawD),
    .readValue2 (rd2D)
  );

  // Branches take the PC in place of Rn
  assign rd1D = regSrc[0] ? pcPlus8D : rd1RawD;

  always_comb begin
    case (immSrc)
      isaPkg::IMM_8: begin
        extImmD = {{(`DATA_WIDTH-8){1'b0}}, instrD[7:0]};
      end
      isaPkg::IMM_12: begin
        extImmD = {{(`DATA_WIDTH-12){1'b0}}, instrD[11:0]};
      end
      isaPkg::IMM_24: begin
        extImmD = {{(`DATA_WIDTH-26){instrD[23]}}, instrD[23:0], 2'b00};
      end
      default: begin
        extImmD = '0;
      end
    endcase
  end

  // Execute
  always_ff @(posedge clk) begin
    rd1E    <= rd1D;
    rd2E    <= rd2D;
    extImmE <= extImmD;
  end

  // Register indices cleared in a bubble so no stale match remains
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ra1E <= '0;
      ra2E <= '0;
      wa3E <= '0;
    end else if (flushE) begin
      ra1E <= '0;
      ra2E <= '0;
      wa3E <= '0;
    end else begin
      ra1E <= ra1D;
      ra2E <= ra2D;
      wa3E <= instrD[15:12];
    end
  end

  assign srcAE      = fwdMux(fwdAE, rd1E, resultW, aluOutM);
  assign writeDataE = fwdMux(fwdBE, rd2E, resultW, aluOutM);
  assign srcBE      = aluSrcE ? extImmE : writeDataE;

  alu aluE (
    .srcA   (srcAE),
    .srcB   (srcBE),
    .op     (aluOpE),
    .result (aluResultE)
  );

  // Memory and writeback payload
  always_ff @(posedge clk) begin
    aluOutM    <= aluResultE;
    writeDataM <= writeDataE;
    aluOutW    <= aluOutM;
    readDataW  <= readDataM;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wa3M <= '0;
      wa3W <= '0;
    end else begin
      wa3M <= wa3E;
      wa3W <= wa3M;
    end
  end

  assign resultW = (resultSrcW == pipePkg::RES_MEM) ? readDataW : aluOutW;

  // Register index comparisons for the hazard unit
  assign match1EM  = (wa3M == ra1E);
  assign match1EW  = (wa3W == ra1E);
  assign match2EM  = (wa3M == ra2E);
  assign match2EW  = (wa3W == ra2E);
  assign match12DE = (wa3E == ra1D) | (wa3E == ra2D);

endmodule

// ==== src/hazardUnit.sv ====
module hazardUnit (
  input  logic             match1EM,
  input  logic             match1EW,
  input  logic             match2EM,
  input  logic             match2EW,
  input  logic             match12DE,
  input  logic             regWriteM,
  input  logic             regWriteW,
  input  logic             memToRegE,
  input  logic             branchE,
  output pipePkg::fwdSelE  fwdAE,
  output pipePkg::fwdSelE  fwdBE,
  output logic             stallF,
  output logic             stallD,
  output logic             flushD,
  output logic             flushE
);

  logic loadUse;

  // Newer result in memory stage takes priority over writeback
  function automatic pipePkg::fwdSelE pickFwd(
    input logic hitM,
    input logic hitW
  );
    if (hitM) begin
      return pipePkg::FWD_MEM;
    end else if (hitW) begin
      return pipePkg::FWD_WB;
    end
    return pipePkg::FWD_REG;
  endfunction

  assign fwdAE = pickFwd(match1EM & regWriteM, match1EW & regWriteW);
  assign fwdBE = pickFwd(match2EM & regWriteM, match2EW & regWriteW);

  // Load data is not ready until writeback so decode holds one cycle
  assign loadUse = memToRegE & match12DE;

  assign stallF = loadUse;
  assign stallD = loadUse;

  // Taken branch kills the two younger instructions
  assign flushD = branchE;
  assign flushE = branchE | loadUse;

endmodule

// ==== src/controller.sv ====
`include "cpuDefs_defs.svh"

module controller (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic [`DATA_WIDTH-1:0] instrD,
  input  logic                   flushE,
  output logic [1:0]             regSrc,
  output isaPkg::immSrcE         immSrc,
  output logic                   aluSrcE,
  output isaPkg::aluOpE          aluOpE,
  output logic                   branchE,
  output logic                   memToRegE,
  output logic                   memWriteM,
  output logic                   regWriteM,
  output logic                   regWriteW,
  output pipePkg::resultSrcE     resultSrcW
);

  isaPkg::instrClassE instrClass;
  isaPkg::aluOpE      aluOpD;
  logic               executeD;
  logic               isLoadD;
  logic               aluSrcD;
  logic               regWriteD;
  logic               memWriteD;
  logic               memToRegD;
  logic               branchD;
  logic               regWriteE;
  logic               memWriteE;
  logic               memToRegM;
  logic               memToRegW;

  // Only AL executes; a flushed all-zero word decodes as a bubble
  assign executeD   = (instrD[31:28] == 4'hE);
  assign isLoadD    = instrD[20];
  assign instrClass = isaPkg::instrClassE'(instrD[27:26]);

  always_comb begin
    regSrc    = 2'b00;
    immSrc    = isaPkg::IMM_8;
    aluSrcD   = 1'b0;
    aluOpD    = isaPkg::OP_ADD;
    regWriteD = 1'b0;
    memWriteD = 1'b0;
    memToRegD = 1'b0;
    branchD   = 1'b0;
    case (instrClass)
      isaPkg::CLS_DP: begin
        aluSrcD   = instrD[25];
        regWriteD = executeD;
        case (isaPkg::aluOpE'(instrD[24:21]))
          isaPkg::OP_AND, isaPkg::OP_EOR, isaPkg::OP_SUB,
          isaPkg::OP_ADD, isaPkg::OP_ORR: begin
            aluOpD = isaPkg::aluOpE'(instrD[24:21]);
          end
          // Undefined opcodes behave like MOV
          default: begin
            aluOpD = isaPkg::OP_MOV;
          end
        endcase
      end
      isaPkg::CLS_MEM: begin
        // Base plus 12-bit offset; stores read Rd as data
        immSrc    = isaPkg::IMM_12;
        aluSrcD   = 1'b1;
        regSrc[1] = ~isLoadD;
        regWriteD = executeD & isLoadD;
        memToRegD = executeD & isLoadD;
        memWriteD = executeD & ~isLoadD;
      end
      isaPkg::CLS_BRANCH: begin
        // Target is PC+8 plus the offset
        immSrc    = isaPkg::IMM_24;
        aluSrcD   = 1'b1;
        regSrc[0] = 1'b1;
        branchD   = executeD;
      end
      default: begin
      end
    endcase
  end

  // Execute stage controls, bubbled on flush
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regWriteE <= 1'b0;
      memWriteE <= 1'b0;
      memToRegE <= 1'b0;
      branchE   <= 1'b0;
      aluSrcE   <= 1'b0;
      aluOpE    <= isaPkg::OP_AND;
    end else if (flushE) begin
      regWriteE <= 1'b0;
      memWriteE <= 1'b0;
      memToRegE <= 1'b0;
      branchE   <= 1'b0;
      aluSrcE   <= 1'b0;
      aluOpE    <= isaPkg::OP_AND;
    end else begin
      regWriteE <= regWriteD;
      memWriteE <= memWriteD;
      memToRegE <= memToRegD;
      branchE   <= branchD;
      aluSrcE   <= aluSrcD;
      aluOpE    <= aluOpD;
    end
  end

  // Memory and writeback stage controls
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
    end else begin
      regWriteM <= regWriteE;
      memWriteM <= memWriteE;
      memToRegM <= memToRegE;
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
    end
  end

  assign resultSrcW = memToRegW ? pipePkg::RES_MEM : pipePkg::RES_ALU;

endmodule

// ==== src/alu.sv ====
`include "cpuDefs_defs.svh"

module alu (
  input  logic [`DATA_WIDTH-1:0] srcA,
  input  logic [`DATA_WIDTH-1:0] srcB,
  input  isaPkg::aluOpE          op,
  output logic [`DATA_WIDTH-1:0] result
);

  always_comb begin
    case (op)
      isaPkg::OP_AND: begin
        result = srcA & srcB;
      end
      isaPkg::OP_EOR: begin
        result = srcA ^ srcB;
      end
      isaPkg::OP_SUB: begin
        result = srcA - srcB;
      end
      isaPkg::OP_ADD: begin
        result = srcA + srcB;
      end
      isaPkg::OP_ORR: begin
        result = srcA | srcB;
      end
      // MOV passes the second operand
      default: begin
        result = srcB;
      end
    endcase
  end

endmodule

// ==== src/regFile.sv ====
`include "cpuDefs_defs.svh"

module regFile (
  input  logic                       clk,
  input  logic                       writeEn,
  input  logic [`REG_ADDR_WIDTH-1:0] readAddr1,
  input  logic [`REG_ADDR_WIDTH-1:0] readAddr2,
  input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
  input  logic [`DATA_WIDTH-1:0]     writeValue,
  output logic [`DATA_WIDTH-1:0]     readValue1,
  output logic [`DATA_WIDTH-1:0]     readValue2
);

  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

  // Falling-edge write, so decode reads the new value in the same cycle
  always_ff @(negedge clk) begin
    if (writeEn) begin
      regs[writeAddr] <= writeValue;
    end
  end

  assign readValue1 = regs[readAddr1];
  assign readValue2 = regs[readAddr2];

endmodule

// ==== src/pipePkg.sv ====
package pipePkg;

  // Execute operand source, in the order of the bypass mux
  typedef enum logic [1:0] {
    FWD_REG = 2'b00,
    FWD_WB  = 2'b01,
    FWD_MEM = 2'b10
  } fwdSelE;

  // Writeback result select
  typedef enum logic {
    RES_ALU = 1'b0,
    RES_MEM = 1'b1
  } resultSrcE;

endpackage

// ==== src/isaPkg.sv ====
package isaPkg;

  // Data-processing opcodes, ARM cmd field values
  typedef enum logic [3:0] {
    OP_AND = 4'b0000,
    OP_EOR = 4'b0001,
    OP_SUB = 4'b0010,
    OP_ADD = 4'b0100,
    OP_ORR = 4'b1100,
    OP_MOV = 4'b1101
  } aluOpE;

  // Instruction class from bits 27:26
  typedef enum logic [1:0] {
    CLS_DP     = 2'b00,
    CLS_MEM    = 2'b01,
    CLS_BRANCH = 2'b10
  } instrClassE;

  // Immediate kinds handled by the extender
  typedef enum logic [1:0] {
    IMM_8  = 2'b00,
    IMM_12 = 2'b01,
    IMM_24 = 2'b10
  } immSrcE;

endpackage

// ==== src/cpuDefs_defs.svh ====
`ifndef CPU_DEFS_DEFS_SVH
`define CPU_DEFS_DEFS_SVH

// Core word size
`define DATA_WIDTH 32

// Register file shape
`define REG_ADDR_WIDTH 4
`define REG_COUNT 16

// Depths of the memories around the core, in words
`define IMEM_WORDS 64
`define DMEM_WORDS 64

`endif
